//--- Bender.yml
package:
  name: exec_unit

sources:
  - files:
      - verilog/execPkg.sv
      - verilog/aluControl.sv
      - verilog/alu.sv
      - verilog/regFile.sv
      - verilog/execUnit.sv
  - target: test
    include_dirs:
      - verification
    files:
      - verification/execUnitTb.sv

//--- src.f
+incdir+verification
verilog/execPkg.sv
verilog/aluControl.sv
verilog/alu.sv
verilog/regFile.sv
verilog/execUnit.sv
verification/execUnitTb.sv

//--- verification/execModel.svh
//--------------------------------------------------
// reference model for the execute slice testbench
//   shadow copy of the register file
//   prediction of result, zero flag and destination
//--------------------------------------------------
`ifndef EXEC_MODEL_SVH
`define EXEC_MODEL_SVH

// one predicted op outcome
typedef struct packed {
  logic [31:0] res;
  logic        zero;
  logic [4:0]  dest;
  logic        wr;
} predictT;

logic [31:0] shadowRegs [32];

// r0 stays zero, every other register takes the write
function automatic void commitWrite(input logic [4:0] addr, input logic [31:0] data);
  if (addr != 5'd0) begin
    shadowRegs[addr] = data;
  end
endfunction

function automatic predictT predictOp(input logic [1:0] op, input logic [5:0] fn,
                                      input logic [4:0] rs, input logic [4:0] rt,
                                      input logic [4:0] rd, input logic [15:0] immVal);
  predictT p;
  logic [31:0] a;
  logic [31:0] b;
  a = shadowRegs[rs];
  b = shadowRegs[rt];
  p.res = 32'd0;
  p.dest = rd;
  p.wr = 1'b0;
  case (op)
    2'b00: begin
      p.wr = 1'b1;
      case (fn)
        6'b100000: p.res = a + b;
        6'b100010: p.res = a - b;
        6'b100100: p.res = a & b;
        6'b100101: p.res = a | b;
        6'b101010: p.res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        default:   p.wr = 1'b0;
      endcase
    end
    2'b01: begin
      // addi, sign-extended immediate into rt
      p.res = a + {{16{immVal[15]}}, immVal};
      p.dest = rt;
      p.wr = 1'b1;
    end
    2'b10: begin
      // xori, zero-extended immediate into rt
      p.res = a ^ {16'h0000, immVal};
      p.dest = rt;
      p.wr = 1'b1;
    end
    default: p.wr = 1'b0;
  endcase
  p.zero = (p.res == 32'd0);
  return p;
endfunction

`endif

//--- verification/execUnitTb.sv
//--------------------------------------------------
// testbench for the execute slice
//   clock, reset and seeded random stimulus
//   ops checked against the shadow model
//   directed after-reset and no-op checks
//--------------------------------------------------
`timescale 1ns/1ns

module execUnitTb;

  `include "execModel.svh"

  localparam int resetTimeout = 20;
  localparam int randomCycles = 340;

  logic             begintest;
  logic             reset;
  logic             loadValid;
  execPkg::regAddrT loadAddr;
  execPkg::dataT    loadData;
  logic             opValid;
  execPkg::aluOpT   aluOp;
  execPkg::functT   funct;
  execPkg::regAddrT rsAddr;
  execPkg::regAddrT rtAddr;
  execPkg::regAddrT rdAddr;
  execPkg::immT     imm;
  logic             resultValid;
  execPkg::dataT    result;
  logic             zero;
  execPkg::regAddrT destAddr;

  int          seed = 90;
  predictT     issued;
  logic        issuedValid;
  predictT     expected;
  logic        expectedValid;
  logic [4:0]  lastDest;

  execUnit u_execUnit (
    .begintest   (begintest),
    .reset       (reset),
    .loadValid   (loadValid),
    .loadAddr    (loadAddr),
    .loadData    (loadData),
    .opValid     (opValid),
    .aluOp       (aluOp),
    .funct       (funct),
    .rsAddr      (rsAddr),
    .rtAddr      (rtAddr),
    .rdAddr      (rdAddr),
    .imm         (imm),
    .resultValid (resultValid),
    .result      (result),
    .zero        (zero),
    .destAddr    (destAddr)
  );

  initial begin
    begintest = 1'b0;
    forever #5 begintest = ~begintest;
  end

  //--------------------------------------------------
  // helpers
  //--------------------------------------------------
  task automatic checkValue(input string what, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
      $display("*** TEST FAILED ***");
      $fatal(1, "stopping at the first mismatch");
    end
  endtask

  // edge where the previous drive is sampled; its prediction becomes due
  task automatic startCycle();
    @(posedge begintest);
    expected = issued;
    expectedValid = issuedValid;
    issuedValid = 1'b0;
    opValid <= 1'b0;
    loadValid <= 1'b0;
  endtask

  // outputs are settled by the falling edge
  task automatic endCycle();
    @(negedge begintest);
    checkValue("resultValid", resultValid, expectedValid);
    if (expectedValid) begin
      checkValue("result", result, expected.res);
      checkValue("zero", zero, expected.zero);
      checkValue("destAddr", destAddr, expected.dest);
    end
  endtask

  task automatic driveLoad(input logic [4:0] addr, input logic [31:0] data);
    loadValid <= 1'b1;
    loadAddr <= addr;
    loadData <= data;
    commitWrite(addr, data);
  endtask

  task automatic driveOp(input logic [1:0] op, input logic [5:0] fn, input logic [4:0] rs,
                         input logic [4:0] rt, input logic [4:0] rd, input logic [15:0] immVal);
    opValid <= 1'b1;
    aluOp <= op;
    funct <= fn;
    rsAddr <= rs;
    rtAddr <= rt;
    rdAddr <= rd;
    imm <= immVal;
    issued = predictOp(op, fn, rs, rt, rd, immVal);
    issuedValid = 1'b1;
    if (issued.wr) begin
      commitWrite(issued.dest, issued.res);
      lastDest = issued.dest;
    end
  endtask

  // mostly valid codes, some random ones that decode to a no-op
  task automatic randomOp();
    logic [31:0] rnd;
    logic [31:0] raw;
    logic [5:0]  fn;
    logic [4:0]  rs;
    logic [4:0]  rt;
    logic [4:0]  rd;
    rnd = $random(seed);
    raw = $random(seed);
    case (rnd[4:2])
      3'd0:    fn = 6'b100000;
      3'd1:    fn = 6'b100010;
      3'd2:    fn = 6'b100100;
      3'd3:    fn = 6'b100101;
      3'd4:    fn = 6'b101010;
      3'd5:    fn = 6'b101010;
      default: fn = raw[21:16];
    endcase
    // bias toward dependent ops and r0 destinations
    rs = (rnd[7:5] == 3'd0) ? lastDest : raw[4:0];
    rt = (rnd[10:8] == 3'd0) ? lastDest : raw[9:5];
    rd = (rnd[13:11] == 3'd0) ? 5'd0 : raw[14:10];
    driveOp(rnd[1:0], fn, rs, rt, rd, rnd[31:16]);
  endtask

  //--------------------------------------------------
  // main sequence
  //--------------------------------------------------
  initial begin
    int          waitCount;
    logic [31:0] rnd;
    reset = 1'b1;
    loadValid = 1'b0;
    loadAddr = '0;
    loadData = '0;
    opValid = 1'b0;
    aluOp = '0;
    funct = '0;
    rsAddr = '0;
    rtAddr = '0;
    rdAddr = '0;
    imm = '0;
    issuedValid = 1'b0;
    issued = '0;
    lastDest = 5'd0;
    for (int i = 0; i < 32; i++) begin
      shadowRegs[i] = 32'd0;
    end

    repeat (4) @(posedge begintest);
    reset <= 1'b0;

    // after reset the output strobe must be low
    waitCount = 0;
    @(negedge begintest);
    while (resultValid !== 1'b0 && waitCount < resetTimeout) begin
      waitCount++;
      @(negedge begintest);
    end
    if (resultValid !== 1'b0) begin
      $display("timeout: resultValid did not go low after reset");
      $display("*** TEST FAILED ***");
      $fatal(1, "reset state never reached");
    end
    checkValue("result after reset", result, 32'd0);

    // no-op on the cleared file, reserved opcode then unknown funct
    startCycle();
    driveOp(2'b11, 6'b100000, 5'd3, 5'd7, 5'd9, 16'h1234);
    endCycle();
    startCycle();
    driveOp(2'b00, 6'b111111, 5'd1, 5'd2, 5'd4, 16'h0000);
    endCycle();

    // or of every register pair reads zero after reset, r0 destination drops the write
    for (int i = 0; i < 32; i++) begin
      startCycle();
      driveOp(2'b00, 6'b100101, i[4:0], ~i[4:0], 5'd0, 16'h0000);
      endCycle();
    end

    // fill every register, r0 included so its write is dropped
    for (int i = 0; i < 32; i++) begin
      startCycle();
      driveLoad(i[4:0], $random(seed));
      endCycle();
    end

    // immediates with the sign bit set
    startCycle();
    driveOp(2'b01, 6'b000000, 5'd5, 5'd6, 5'd0, 16'h8001);
    endCycle();
    startCycle();
    driveOp(2'b10, 6'b000000, 5'd6, 5'd7, 5'd0, 16'hf0f0);
    endCycle();

    // random ops with the odd load or idle cycle
    for (int i = 0; i < randomCycles; i++) begin
      rnd = $random(seed);
      startCycle();
      if (rnd[3:0] == 4'd0) begin
        driveLoad(rnd[8:4], $random(seed));
      end else if (rnd[3:0] != 4'd1) begin
        randomOp();
      end
      endCycle();
    end

    // drain the last op
    startCycle();
    endCycle();

    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule

//--- verilog/alu.sv
//--------------------------------------------------
// combinational 32-bit ALU
//   add, sub, slt (signed), and, or, xor
//   zero flag on an all-zero result
//--------------------------------------------------
`timescale 1ns/1ns

module alu (
  input  execPkg::aluCtrlE op,
  input  execPkg::dataT    a,
  input  execPkg::dataT    b,
  output execPkg::dataT    res,
  output logic             zero
);

  // signed compare for slt
  logic lessThan;

  // shared subtractor, also feeds nothing else
  execPkg::dataT diff;

  assign diff     = a - b;
  assign lessThan = $signed(a) < $signed(b);

  //--------------------------------------------------
  // operation select
  //--------------------------------------------------
  always_comb begin
    case (op)
      execPkg::aluAdd: begin
        // wraps on overflow, no trap
        res = a + b;
      end
      execPkg::aluSub: begin
        res = diff;
      end
      execPkg::aluSlt: begin
        // 1 or 0 in the low bit
        res = {{(execPkg::dataWidth-1){1'b0}}, lessThan};
      end
      execPkg::aluAnd: begin
        res = a & b;
      end
      execPkg::aluOr: begin
        res = a | b;
      end
      execPkg::aluXor: begin
        res = a ^ b;
      end
      default: begin
        // aluNone and unused codes give 0
        res = '0;
      end
    endcase
  end

  // flag follows the selected result only
  assign zero = (res == '0);

endmodule

//--- verilog/aluControl.sv
//--------------------------------------------------
// ALU control decoder
//   ALU opcode + function field to decoded control
//   covers R-type, addi and xori
//--------------------------------------------------
`timescale 1ns/1ns

module aluControl (
  input  execPkg::aluOpT  aluOp,
  input  execPkg::functT  funct,
  output execPkg::decodeT ctrl
);

  always_comb begin
    // default is a no-op that writes nothing
    ctrl.op       = execPkg::aluNone;
    ctrl.immKind  = execPkg::immNone;
    ctrl.destIsRt = 1'b0;
    ctrl.writeEn  = 1'b0;

    case (aluOp)
      execPkg::opRType: begin
        // register operands, result goes to rd
        ctrl.writeEn = 1'b1;
        case (funct)
          execPkg::fnAdd: ctrl.op = execPkg::aluAdd;
          execPkg::fnSub: ctrl.op = execPkg::aluSub;
          execPkg::fnAnd: ctrl.op = execPkg::aluAnd;
          execPkg::fnOr:  ctrl.op = execPkg::aluOr;
          execPkg::fnSlt: ctrl.op = execPkg::aluSlt;
          default: begin
            // unknown function code, nothing written
            ctrl.op      = execPkg::aluNone;
            ctrl.writeEn = 1'b0;
          end
        endcase
      end
      execPkg::opAddi: begin
        ctrl.op       = execPkg::aluAdd;
        ctrl.immKind  = execPkg::immSign;
        ctrl.destIsRt = 1'b1;
        ctrl.writeEn  = 1'b1;
      end
      execPkg::opXori: begin
        // logical immediates are zero-extended
        ctrl.op       = execPkg::aluXor;
        ctrl.immKind  = execPkg::immZero;
        ctrl.destIsRt = 1'b1;
        ctrl.writeEn  = 1'b1;
      end
      default: begin
        // reserved opcode keeps the no-op defaults
        ctrl.op = execPkg::aluNone;
      end
    endcase
  end

endmodule

//--- verilog/execPkg.sv
//--------------------------------------------------
// shared definitions for the execute slice
//   widths and word typedefs
//   ALU operation and immediate kind enums
//   decoded control struct
//   ALU opcode and R-type function codes
//--------------------------------------------------
package execPkg;

  // widths
  localparam int dataWidth    = 32;
  localparam int regAddrWidth = 5;
  localparam int regCount     = 1 << regAddrWidth;
  localparam int functWidth   = 6;
  localparam int immWidth     = 16;

  typedef logic [dataWidth-1:0]    dataT;
  typedef logic [regAddrWidth-1:0] regAddrT;
  typedef logic [functWidth-1:0]   functT;
  typedef logic [1:0]              aluOpT;
  typedef logic [immWidth-1:0]     immT;

  // 3-bit ALU control word, classic encodings for and/or/add/sub/slt
  typedef enum logic [2:0] {
    aluAnd  = 3'b000,
    aluOr   = 3'b001,
    aluAdd  = 3'b010,
    aluXor  = 3'b011,
    aluNone = 3'b100,
    aluSub  = 3'b110,
    aluSlt  = 3'b111
  } aluCtrlE;

  // where operand b comes from
  typedef enum logic [1:0] {
    immNone = 2'b00,
    immSign = 2'b01,
    immZero = 2'b10
  } immKindE;

  typedef struct packed {
    aluCtrlE op;
    immKindE immKind;
    logic    destIsRt;
    logic    writeEn;
  } decodeT;

  // ALU opcodes from the main decoder (11 is reserved)
  localparam aluOpT opRType = 2'b00;
  localparam aluOpT opAddi  = 2'b01;
  localparam aluOpT opXori  = 2'b10;

  // R-type function codes
  localparam functT fnAdd = 6'b100000;
  localparam functT fnSub = 6'b100010;
  localparam functT fnAnd = 6'b100100;
  localparam functT fnOr  = 6'b100101;
  localparam functT fnSlt = 6'b101010;

endpackage

//--- verilog/execUnit.sv
//--------------------------------------------------
// execute slice top level
//   register file, ALU control decoder and ALU
//   operand b select and write port mux
//   registered result group, one cycle latency
//--------------------------------------------------
`timescale 1ns/1ns

module execUnit (
  input  logic             begintest,
  input  logic             reset,
  // external load port
  input  logic             loadValid,
  input  execPkg::regAddrT loadAddr,
  input  execPkg::dataT    loadData,
  // op strobe and fields
  input  logic             opValid,
  input  execPkg::aluOpT   aluOp,
  input  execPkg::functT   funct,
  input  execPkg::regAddrT rsAddr,
  input  execPkg::regAddrT rtAddr,
  input  execPkg::regAddrT rdAddr,
  input  execPkg::immT     imm,
  // result strobe
  output logic             resultValid,
  output execPkg::dataT    result,
  output logic             zero,
  output execPkg::regAddrT destAddr
);

  // output group, registered together
  typedef struct packed {
    logic             valid;
    execPkg::dataT    result;
    logic             zero;
    execPkg::regAddrT destAddr;
  } resultT;

  execPkg::decodeT  ctrl;
  execPkg::dataT    rsData;
  execPkg::dataT    rtData;
  execPkg::dataT    opB;
  execPkg::dataT    aluRes;
  logic             aluZero;
  execPkg::regAddrT opDest;
  logic             wrEn;
  execPkg::regAddrT wrAddr;
  execPkg::dataT    wrData;
  resultT           outQ;

  aluControl uAluControl (
    .aluOp (aluOp),
    .funct (funct),
    .ctrl  (ctrl)
  );

  regFile uRegFile (
    .begintest (begintest),
    .reset     (reset),
    .rsAddr    (rsAddr),
    .rtAddr    (rtAddr),
    .rsData    (rsData),
    .rtData    (rtData),
    .writeEn   (wrEn),
    .writeAddr (wrAddr),
    .writeData (wrData)
  );

  //--------------------------------------------------
  // operand b
  //--------------------------------------------------
  always_comb begin
    case (ctrl.immKind)
      execPkg::immSign: opB = {{(execPkg::dataWidth-execPkg::immWidth){imm[execPkg::immWidth-1]}},
                               imm};
      execPkg::immZero: opB = {{(execPkg::dataWidth-execPkg::immWidth){1'b0}}, imm};
      default:          opB = rtData;
    endcase
  end

  alu uAlu (
    .op   (ctrl.op),
    .a    (rsData),
    .b    (opB),
    .res  (aluRes),
    .zero (aluZero)
  );

  // immediates write rt, R-type writes rd
  assign opDest = ctrl.destIsRt ? rtAddr : rdAddr;

  //--------------------------------------------------
  // write port mux, load wins
  //--------------------------------------------------
  assign wrEn   = loadValid || (opValid && ctrl.writeEn);
  assign wrAddr = loadValid ? loadAddr : opDest;
  assign wrData = loadValid ? loadData : aluRes;

  //--------------------------------------------------
  // output register
  //--------------------------------------------------
  always_ff @(posedge begintest) begin
    if (reset) begin
      // empty result reads as zero
      outQ <= '{valid: 1'b0, result: '0, zero: 1'b1, destAddr: '0};
    end else begin
      outQ.valid <= opValid;
      // payload holds between ops
      if (opValid) begin
        outQ.result   <= aluRes;
        outQ.zero     <= aluZero;
        outQ.destAddr <= opDest;
      end
    end
  end

  assign resultValid = outQ.valid;
  assign result      = outQ.result;
  assign zero        = outQ.zero;
  assign destAddr    = outQ.destAddr;

  // load and op share the one write port
  assert property (@(posedge begintest) disable iff (reset)
    !(loadValid && opValid))
    else $error("execUnit: load and op in the same cycle");

endmodule

//--- verilog/regFile.sv
//--------------------------------------------------
// 32 x 32 register file
//   two combinational read ports, one write port
//   register 0 is never written and reads zero
//--------------------------------------------------
`timescale 1ns/1ns

module regFile (
  input  logic             begintest,
  input  logic             reset,
  input  execPkg::regAddrT rsAddr,
  input  execPkg::regAddrT rtAddr,
  output execPkg::dataT    rsData,
  output execPkg::dataT    rtData,
  input  logic             writeEn,
  input  execPkg::regAddrT writeAddr,
  input  execPkg::dataT    writeData
);

  // storage array
  execPkg::dataT mem [execPkg::regCount];

  // write to r0 is dropped here
  logic writeOk;

  assign writeOk = writeEn && (writeAddr != '0);

  //--------------------------------------------------
  // write port
  //--------------------------------------------------
  always_ff @(posedge begintest) begin
    if (reset) begin
      // whole array cleared, r0 included
      for (int i = 0; i < execPkg::regCount; i++) begin
        mem[i] <= '0;
      end
    end else if (writeOk) begin
      mem[writeAddr] <= writeData;
    end
  end

  // reads see the array directly, no bypass
  assign rsData = mem[rsAddr];
  assign rtData = mem[rtAddr];

  //--------------------------------------------------
  // checks
  //--------------------------------------------------

  // r0 stays zero across all writes since reset
  assert property (@(posedge begintest) disable iff (reset)
    (rsAddr == '0) |-> (rsData == '0))
    else $error("regFile: register 0 read back nonzero");

  assert property (@(posedge begintest) disable iff (reset)
    (rtAddr == '0) |-> (rtData == '0))
    else $error("regFile: register 0 read back nonzero");

  // write address must be known while writing
  assert property (@(posedge begintest) disable iff (reset)
    writeEn |-> !$isunknown(writeAddr))
    else $error("regFile: unknown write address");

endmodule
